// ==== cpuCore.f ====
+incdir+tests
source/cpuIsaPkg.sv
source/cpuCtrlPkg.sv
source/cpuAlu.sv
source/cpuRegisters.sv
source/cpuController.sv
source/cpuCore.sv
tests/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpuCore testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cpuCoreTb -f cpuCore.f

# A failing run still prints its output, the search below decides the status
simOut=$(./obj_dir/VcpuCoreTb || true)
printf '%s\n' "$simOut"

printf '%s\n' "$simOut" | grep -q '^Simulation PASSED$'
echo "run.sh: simulation passed"

// ==== source/cpuAlu.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuAlu (
    input wire cpuCtrlPkg::ctrlBundle_t ctrl,
    input wire cpuIsaPkg::word_t opA,
    input wire cpuIsaPkg::word_t opB,
    output cpuIsaPkg::word_t result,
    output cpuIsaPkg::flags_t aluFlags
);
    import cpuIsaPkg::*;

    logic [dataWidth:0] sum;
    logic [dataWidth:0] diff;   // Top bit is the borrow
    logic addOvf;
    logic subOvf;

    assign sum = {1'b0, opA} + {1'b0, opB};
    assign diff = {1'b0, opA} - {1'b0, opB};
    assign addOvf = (opA[dataWidth-1] == opB[dataWidth-1])
        && (sum[dataWidth-1] != opA[dataWidth-1]);
    assign subOvf = (opA[dataWidth-1] != opB[dataWidth-1])
        && (diff[dataWidth-1] != opA[dataWidth-1]);

    always_comb begin
        aluFlags.carry = 1'b0;
        aluFlags.overflow = 1'b0;
        case (ctrl.func)
            aluSub: begin
                result = diff[dataWidth-1:0];
                aluFlags.carry = diff[dataWidth];
                aluFlags.overflow = subOvf;
            end
            aluAnd: result = opA & opB;
            aluOr: result = opA | opB;
            aluXor: result = opA ^ opB;
            aluShl: result = opA << opB[3:0];
            aluShr: result = opA >> opB[3:0];   // Logical shift
            aluPassB: result = opB;
            default: begin   // Add and every spare code
                result = sum[dataWidth-1:0];
                aluFlags.carry = sum[dataWidth];
                aluFlags.overflow = addOvf;
            end
        endcase
        aluFlags.negative = result[dataWidth-1];
        aluFlags.zero = result == '0;
    end

endmodule

`default_nettype wire

// ==== source/cpuController.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuController (
    input wire clk,
    input wire rst,
    input wire cpuIsaPkg::word_t readData,
    input wire cpuIsaPkg::flags_t flags,
    output cpuCtrlPkg::ctrlBundle_t ctrl,
    output logic halted
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    ctrlState_t state;
    ctrlState_t nextState;
    instr_t ir;
    instr_t cur;   // Word being decoded in this cycle
    logic isA;
    logic isI;
    logic isJ;
    logic isF;
    logic isPush;
    logic isPop;
    logic fTaken;
    logic [13:0] jumpOfs;
    word_t immWord;

    function automatic opndSel_t regOpnd(logic [1:0] code);
        opndSel_t sel;
        sel = opndZero;
        case (code)
            regZero: sel = opndZero;
            regA: sel = opndA;
            regB: sel = opndB;
            regC: sel = opndC;
        endcase
        return sel;
    endfunction

    // Register or memory-at-A destination, code 0 is left to the caller
    function automatic ctrlBundle_t applyDest(ctrlBundle_t b, logic [2:0] dest);
        ctrlBundle_t r;
        r = b;
        case (dest)
            destA: r.enA = 1'b1;
            destB: r.enB = 1'b1;
            destC: r.enC = 1'b1;
            destMemA: begin
                r.we = 1'b1;
                r.addrSel = addrA;
            end
            default: ;
        endcase
        return r;
    endfunction

    // In fetch the new word comes straight off the bus
    assign cur = (state == stFetch) ? instr_t'(readData) : ir;

    assign isA = cur.regView.cls == clsA && !cur.regView.src[2]
        && cur.regView.dest <= destMemA && cur.regView.func != aluMulRsvd;
    assign isI = cur.immView.cls == clsI && (!cur.immView.rd[2]
        || (cur.immView.rd == destMemA && cur.immView.funcHi
            && cur.immView.funcLo == 2'b11));   // Immediate store at A
    assign isJ = cur.immView.cls == clsJ;
    assign isF = cur.regView.cls == clsF && !cur.immView.funcHi;
    assign isPush = cur.regView.cls == clsStack && cur.regView.func[3:2] == stackPush
        && !cur.regView.src[2];
    assign isPop = cur.regView.cls == clsStack && cur.regView.func[3:2] == stackPop
        && cur.regView.src <= destMemA;
    assign fTaken = flags[cur.regView.src[1:0]] == cur.regView.src[2];

    assign jumpOfs = {cur.immView.funcLo, cur.immView.rd, cur.immView.funcHi, cur.immView.imm};
    assign immWord = isJ ? {{2{jumpOfs[13]}}, jumpOfs}
                         : {{8{cur.immView.imm[7]}}, cur.immView.imm};

    assign halted = state == stHalt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stStart;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == stFetch) ir <= readData;
    end

    always_comb begin
        nextState = stHalt;   // Illegal words and halt end up here
        case (state)
            stStart: nextState = stFetch;
            stFetch: begin
                if (isA || isI || isJ || isPush || isPop || (isF && fTaken)) begin
                    nextState = stExecute;
                end else if (isF) begin
                    nextState = stFetch;   // Branch not taken
                end
            end
            stExecute: begin
                if (isPush) nextState = stPush2;
                else if (isPop) nextState = stPop2;
                else nextState = stFetch;
            end
            stPush2, stPop2: nextState = stFetch;
            default: nextState = stHalt;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (state)
            stStart: begin   // Zero operands give PC = 0
                ctrl.initStack = 1'b1;
                ctrl.enSP = 1'b1;
                ctrl.enPC = 1'b1;
            end
            stFetch: begin
                ctrl.re = 1'b1;
                ctrl.addrSel = addrPc;
                ctrl.func = aluAdd;
                ctrl.selA = opndPc;
                ctrl.selB = opndImm;
                ctrl.imm = stepOne;
                ctrl.enPC = 1'b1;
            end
            stExecute: begin
                ctrl.imm = immWord;
                if (isA) begin
                    ctrl.func = cur.regView.func;
                    ctrl.selA = regOpnd(cur.regView.src[1:0]);
                    ctrl.selB = regOpnd(cur.regView.src2);
                    ctrl.enF = |cur;   // NOP keeps the flags
                    ctrl = applyDest(ctrl, cur.regView.dest);
                end else if (isI) begin
                    ctrl.func = {{2{cur.immView.funcHi}}, cur.immView.funcLo};
                    ctrl.selA = (cur.immView.rd == destNone) ? opndSp
                                                             : regOpnd(cur.immView.rd[1:0]);
                    ctrl.selB = opndImm;
                    ctrl.enF = 1'b1;
                    ctrl.enSP = cur.immView.rd == destNone;
                    ctrl = applyDest(ctrl, cur.immView.rd);
                end else if (isPush) begin
                    ctrl.func = aluAdd;
                    ctrl.selA = regOpnd(cur.regView.src[1:0]);
                    ctrl.we = 1'b1;
                    ctrl.addrSel = addrSp;
                end else if (isPop) begin   // Read at SP + 1
                    ctrl.func = aluAdd;
                    ctrl.selA = opndSp;
                    ctrl.selB = opndImm;
                    ctrl.imm = stepOne;
                    ctrl.enSP = 1'b1;
                    ctrl.re = 1'b1;
                    ctrl.addrSel = addrAlu;
                    ctrl.enMem = 1'b1;
                end else begin   // J-type or taken F-type
                    ctrl.func = aluAdd;
                    ctrl.selA = opndPc;
                    ctrl.selB = opndImm;
                    ctrl.enPC = 1'b1;
                end
            end
            stPush2: begin
                ctrl.func = aluSub;
                ctrl.selA = opndSp;
                ctrl.selB = opndImm;
                ctrl.imm = stepOne;
                ctrl.enSP = 1'b1;
            end
            stPop2: begin
                ctrl.func = aluAdd;
                ctrl.selA = opndMem;
                ctrl.flagSrc = 1'b1;
                ctrl.enF = cur.regView.src == destNone;
                ctrl = applyDest(ctrl, cur.regView.src);
            end
            default: ;
        endcase
        if (rst) ctrl = '0;   // No strobes or enables in reset
    end

    // Bus strobes are exclusive in every state
    assert property (@(posedge clk) disable iff (rst) !(ctrl.re && ctrl.we));

    // Only reset brings the core out of halt
    assert property (@(posedge clk) disable iff (rst) state == stHalt |=> state == stHalt);

endmodule

`default_nettype wire

// ==== source/cpuCore.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCore (
    input wire clk,
    input wire rst,
    input wire cpuIsaPkg::word_t readData,
    output cpuIsaPkg::word_t memAddr,
    output cpuIsaPkg::word_t writeData,
    output logic re,
    output logic we,
    output logic halted
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    ctrlBundle_t ctrl;
    word_t opA;
    word_t opB;
    word_t result;
    flags_t aluFlags;
    flags_t flags;   // Flag register, for branch decisions

    cpuController u_cpuController (
        .clk(clk),
        .rst(rst),
        .readData(readData),
        .flags(flags),
        .ctrl(ctrl),
        .halted(halted)
    );

    cpuRegisters u_cpuRegisters (
        .clk(clk),
        .rst(rst),
        .ctrl(ctrl),
        .result(result),
        .aluFlags(aluFlags),
        .readData(readData),
        .opA(opA),
        .opB(opB),
        .memAddr(memAddr),
        .flags(flags)
    );

    cpuAlu u_cpuAlu (
        .ctrl(ctrl),
        .opA(opA),
        .opB(opB),
        .result(result),
        .aluFlags(aluFlags)
    );

    assign writeData = result;   // Stores always carry the ALU result
    assign re = ctrl.re;
    assign we = ctrl.we;

endmodule

`default_nettype wire

// ==== source/cpuCtrlPkg.sv ====
`default_nettype none

package cpuCtrlPkg;

    // Step used for PC increment and stack pointer moves
    localparam cpuIsaPkg::word_t stepOne = 16'd1;

    typedef enum logic [2:0] {
        stStart,
        stFetch,
        stExecute,
        stPush2,
        stPop2,
        stHalt
    } ctrlState_t;

    // Memory address source
    typedef enum logic [1:0] {
        addrPc,
        addrA,
        addrSp,
        addrAlu
    } addrSel_t;

    // ALU operand source, first four follow the register codes
    typedef enum logic [2:0] {
        opndZero,
        opndA,
        opndB,
        opndC,
        opndSp,
        opndPc,
        opndMem,
        opndImm
    } opndSel_t;

    typedef struct packed {
        cpuIsaPkg::aluFunc_t func;
        opndSel_t selA;
        opndSel_t selB;
        cpuIsaPkg::word_t imm;   // Sign-extended immediate or offset
        addrSel_t addrSel;
        logic enA;
        logic enB;
        logic enC;
        logic enPC;
        logic enSP;
        logic enF;
        logic enMem;   // Latch readData into the memory-value register
        logic flagSrc;   // Set to load flags from result[3:0]
        logic re;
        logic we;
        logic initStack;   // SP gets stackTop instead of the result
    } ctrlBundle_t;

endpackage

`default_nettype wire

// ==== source/cpuIsaPkg.sv ====
`default_nettype none

package cpuIsaPkg;

    localparam int dataWidth = 16;

    typedef logic [dataWidth-1:0] word_t;   // Data and address word

    typedef logic [3:0] aluFunc_t;

    // ALU function codes, anything not listed adds
    localparam aluFunc_t aluAdd = 4'b0000;
    localparam aluFunc_t aluAnd = 4'b0001;
    localparam aluFunc_t aluSub = 4'b0010;
    localparam aluFunc_t aluOr = 4'b0011;
    localparam aluFunc_t aluMulRsvd = 4'b0100;   // Old multiply, illegal in A-type
    localparam aluFunc_t aluXor = 4'b1100;
    localparam aluFunc_t aluShl = 4'b1101;
    localparam aluFunc_t aluShr = 4'b1110;
    localparam aluFunc_t aluPassB = 4'b1111;

    // Register source codes
    localparam logic [1:0] regZero = 2'd0;
    localparam logic [1:0] regA = 2'd1;
    localparam logic [1:0] regB = 2'd2;
    localparam logic [1:0] regC = 2'd3;

    // Destination codes, 5 to 7 are illegal
    localparam logic [2:0] destNone = 3'd0;   // SP for I-type, flags for POP
    localparam logic [2:0] destA = 3'd1;
    localparam logic [2:0] destB = 3'd2;
    localparam logic [2:0] destC = 3'd3;
    localparam logic [2:0] destMemA = 3'd4;

    // Instruction classes
    localparam logic [3:0] clsA = 4'b0000;
    localparam logic [3:0] clsF = 4'b0010;   // Also needs bit 8 clear
    localparam logic [3:0] clsStack = 4'b0011;
    localparam logic [1:0] clsI = 2'b01;
    localparam logic [1:0] clsJ = 2'b11;

    // Stack operation, bits 8:7
    localparam logic [1:0] stackPush = 2'b00;
    localparam logic [1:0] stackPop = 2'b01;

    localparam word_t stackTop = 16'hFF00;

    // Carry sits at bit 0 so the F-type condition index 0 picks it
    typedef struct packed {
        logic zero;
        logic negative;
        logic overflow;
        logic carry;
    } flags_t;

    typedef struct packed {
        logic [3:0] cls;
        logic [2:0] src;   // Also F-type wanted value and flag index
        aluFunc_t func;   // Bits 8:7 select the stack operation
        logic [1:0] src2;
        logic [2:0] dest;
    } instrReg_t;

    typedef struct packed {
        logic [1:0] cls;
        logic [1:0] funcLo;
        logic [2:0] rd;   // Source and destination of I-type
        logic funcHi;
        logic [7:0] imm;   // Also F-type offset
    } instrImm_t;

    typedef union packed {
        instrReg_t regView;
        instrImm_t immView;
    } instr_t;

endpackage

`default_nettype wire

// ==== source/cpuRegisters.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuRegisters (
    input wire clk,
    input wire rst,
    input wire cpuCtrlPkg::ctrlBundle_t ctrl,
    input wire cpuIsaPkg::word_t result,
    input wire cpuIsaPkg::flags_t aluFlags,
    input wire cpuIsaPkg::word_t readData,
    output cpuIsaPkg::word_t opA,
    output cpuIsaPkg::word_t opB,
    output cpuIsaPkg::word_t memAddr,
    output cpuIsaPkg::flags_t flags
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    word_t aReg;
    word_t bReg;
    word_t cReg;
    word_t pcReg;
    word_t spReg;
    word_t memVal;   // Value latched by POP
    flags_t flagReg;

    function automatic word_t pickOpnd(opndSel_t sel);
        word_t v;
        case (sel)
            opndA: v = aReg;
            opndB: v = bReg;
            opndC: v = cReg;
            opndSp: v = spReg;
            opndPc: v = pcReg;
            opndMem: v = memVal;
            opndImm: v = ctrl.imm;
            default: v = '0;   // Zero register
        endcase
        return v;
    endfunction

    assign opA = pickOpnd(ctrl.selA);
    assign opB = pickOpnd(ctrl.selB);
    assign flags = flagReg;

    always_comb begin
        case (ctrl.addrSel)
            addrA: memAddr = aReg;
            addrSp: memAddr = spReg;
            addrAlu: memAddr = result;   // POP reads at SP + 1
            default: memAddr = pcReg;
        endcase
    end

    // General registers and flags start from zero
    always_ff @(posedge clk) begin
        if (rst) begin
            aReg <= '0;
            bReg <= '0;
            cReg <= '0;
            flagReg <= '0;
        end else begin
            if (ctrl.enA) aReg <= result;
            if (ctrl.enB) bReg <= result;
            if (ctrl.enC) cReg <= result;
            if (ctrl.enF) flagReg <= ctrl.flagSrc ? flags_t'(result[3:0]) : aluFlags;
        end
    end

    // PC and SP are set up by the start state
    always_ff @(posedge clk) begin
        if (ctrl.enPC) pcReg <= result;
        if (ctrl.enSP) spReg <= ctrl.initStack ? stackTop : result;
        if (ctrl.enMem) memVal <= readData;
    end

    assert property (@(posedge clk) disable iff (rst)
        (ctrl.enSP && ctrl.enPC) |-> ctrl.initStack);

    // Memory value is consumed right after the POP read
    assert property (@(posedge clk) disable iff (rst)
        (ctrl.selA == opndMem || ctrl.selB == opndMem) |-> $past(ctrl.enMem));

endmodule

`default_nettype wire

// ==== tests/cpuModel.svh ====
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

typedef struct packed {
    logic isWrite;
    word_t addr;
    word_t data;   // Only used for writes
} busEvent_t;

busEvent_t expQ[$];   // Expected bus events in order
word_t modelMem [0:65535];
word_t modelReg [0:3];   // Entry 0 is the zero register
word_t modelPc;
word_t modelSp;
flags_t modelFlags;

function automatic void resetModel();
    modelPc = '0;
    modelSp = stackTop;
    modelFlags = '0;
    modelReg = '{default: '0};
    expQ.delete();
endfunction

function automatic void expectEvent(input logic isWrite, input word_t addr, input word_t data);
    busEvent_t ev;
    ev.isWrite = isWrite;
    ev.addr = addr;
    ev.data = data;
    expQ.push_back(ev);
endfunction

function automatic void storeWord(input word_t addr, input word_t value);
    modelMem[addr] = value;
    expectEvent(1'b1, addr, value);
endfunction

function automatic void writeDest(input logic [2:0] dest, input word_t value);
    if (dest == destMemA) storeWord(modelReg[regA], value);
    else if (dest != destNone) modelReg[dest[1:0]] = value;
endfunction

function automatic word_t aluReference(input aluFunc_t fn, input word_t a, input word_t b,
                                       output flags_t f);
    logic [16:0] wide;
    word_t r;
    f = '0;
    case (fn)
        aluAnd: r = a & b;
        aluOr: r = a | b;
        aluXor: r = a ^ b;
        aluShl: r = a << b[3:0];
        aluShr: r = a >> b[3:0];
        aluPassB: r = b;
        aluSub: begin
            wide = {1'b0, a} - {1'b0, b};
            r = wide[15:0];
            f.carry = a < b;   // Borrow
            f.overflow = (a[15] ^ b[15]) & (a[15] ^ r[15]);
        end
        default: begin   // Add and spare codes
            wide = {1'b0, a} + {1'b0, b};
            r = wide[15:0];
            f.carry = wide[16];
            f.overflow = ~(a[15] ^ b[15]) & (a[15] ^ r[15]);
        end
    endcase
    f.negative = r[15];
    f.zero = r == 16'h0;
    return r;
endfunction

// Executes one instruction, returns 1 when the word is illegal
function automatic logic stepModel();
    word_t w;
    word_t imm;
    word_t res;
    word_t val;
    flags_t f;
    logic [3:0] fbits;
    aluFunc_t fn;
    w = modelMem[modelPc];
    expectEvent(1'b0, modelPc, '0);   // Fetch
    modelPc = modelPc + 16'd1;
    imm = {{8{w[7]}}, w[7:0]};
    fbits = modelFlags;
    fn = {w[8], w[8], w[13:12]};
    if (w[15:12] == 4'b0000) begin   // A-type
        if (w[11] || w[2:0] > destMemA || w[8:5] == aluMulRsvd) return 1'b1;
        res = aluReference(w[8:5], modelReg[w[10:9]], modelReg[w[4:3]], f);
        if (w != 16'h0) modelFlags = f;   // NOP keeps flags
        writeDest(w[2:0], res);
    end else if (w[15:14] == 2'b01) begin   // I-type
        if (w[11:9] > destMemA || (w[11:9] == destMemA && fn != aluPassB)) return 1'b1;
        res = aluReference(fn, (w[11:9] == destNone) ? modelSp : modelReg[w[10:9]], imm, f);
        modelFlags = f;
        if (w[11:9] == destNone) modelSp = res;
        else writeDest(w[11:9], res);
    end else if (w[15:14] == 2'b11) begin
        modelPc = modelPc + {{2{w[13]}}, w[13:0]};
    end else if (w[15:12] == 4'b0010 && !w[8]) begin   // Branch on one flag
        if (fbits[w[10:9]] == w[11]) modelPc = modelPc + imm;
    end else if (w[15:12] == 4'b0011 && w[8:7] == 2'b00 && !w[11]) begin
        storeWord(modelSp, modelReg[w[10:9]]);   // PUSH
        modelSp = modelSp - 16'd1;
    end else if (w[15:12] == 4'b0011 && w[8:7] == 2'b01 && w[11:9] <= destMemA) begin
        modelSp = modelSp + 16'd1;   // POP
        val = modelMem[modelSp];
        expectEvent(1'b0, modelSp, '0);
        if (w[11:9] == destNone) modelFlags = flags_t'(val[3:0]);
        else writeDest(w[11:9], val);
    end else begin
        return 1'b1;
    end
    return 1'b0;
endfunction

function automatic word_t randomInstr();
    logic [31:0] r;
    logic [2:0] d;
    aluFunc_t fn;
    r = $random(seed);
    d = (r[2:0] > destMemA) ? {1'b0, r[1:0]} : r[2:0];
    fn = (r[8:5] == aluMulRsvd) ? aluAdd : r[8:5];
    case (r[31:28])
        4'd0: return 16'h0000;   // NOP
        4'd1, 4'd2, 4'd3: return {4'b0000, 1'b0, r[10:9], fn, r[4:3], d};
        4'd4, 4'd5, 4'd6: return {2'b01, r[13:12], 1'b0, r[10:9], r[8], r[7:0]};
        4'd7: return {2'b01, 2'b11, destMemA, 1'b1, r[7:0]};   // Store immediate at A
        4'd8: return {2'b11, r[13:0]};
        4'd9, 4'd10, 4'd11: return {4'b0010, r[11:9], 1'b0, r[7:0]};
        4'd12, 4'd13: return {4'b0011, 1'b0, r[10:9], 2'b00, r[6:0]};
        default: return {4'b0011, d, 2'b01, r[6:0]};
    endcase
endfunction

function automatic void loadProgram();
    word_t a;
    word_t w;
    a = '0;
    do begin
        w = randomInstr();
        mem[a] = w;
        modelMem[a] = w;
        a = a + 16'd1;
    end while (a != 16'h0);
endfunction

// Trial run finds the PC of a later fetch, the illegal word goes there
function automatic void plantIllegal();
    logic [31:0] r;
    word_t a;
    int steps;
    r = $random(seed);
    steps = 20 + int'(r[6:0]);
    resetModel();
    for (int n = 0; n < steps; n++) begin
        void'(stepModel());
    end
    a = '0;
    do begin
        modelMem[a] = mem[a];   // Undo the trial stores
        a = a + 16'd1;
    end while (a != 16'h0);
    mem[modelPc] = {2'b10, r[21:8]};   // Class 10 never decodes
    modelMem[modelPc] = {2'b10, r[21:8]};
endfunction

`endif

// ==== tests/cpuCoreTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpuCoreTb;
    import cpuIsaPkg::*;

    localparam int clkPeriod = 20;
    localparam int resetCycles = 8;
    localparam int numRuns = 40;
    localparam int instrPerRun = 200;
    localparam int watchdogCycles = numRuns * (instrPerRun * 10 + resetCycles + 20);

    logic clk;
    logic rst;
    word_t readData;
    word_t memAddr;
    word_t writeData;
    logic re;
    logic we;
    logic halted;

    word_t mem [0:65535];
    int seed;
    int eventNum;

    `include "cpuModel.svh"

    cpuCore u_cpuCore (
        .clk(clk),
        .rst(rst),
        .readData(readData),
        .memAddr(memAddr),
        .writeData(writeData),
        .re(re),
        .we(we),
        .halted(halted)
    );

    assign readData = mem[memAddr];   // Same-cycle read

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic compareAddr(input string testName, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            abortRun($sformatf("FAIL %s address: expected %h, actual %h",
                testName, expected, actual));
        end
    endtask

    task automatic compareData(input string testName, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            abortRun($sformatf("FAIL %s write data: expected %h, actual %h",
                testName, expected, actual));
        end
    endtask

    task automatic compareHalted(input string testName, input logic expected, input logic actual);
        if (expected !== actual) begin
            abortRun($sformatf("FAIL %s halted: expected %b, actual %b",
                testName, expected, actual));
        end
    endtask

    // Called at the falling edge, the access completes at the next rising edge
    task automatic sampleBus(input int run);
        busEvent_t ev;
        string testName;
        if (re || we) begin
            testName = $sformatf("run %0d bus event %0d", run, eventNum);
            eventNum++;
            if (expQ.size() == 0) begin
                abortRun($sformatf("%s: bus access after the last expected one", testName));
            end else begin
                ev = expQ.pop_front();
                if (ev.isWrite !== we) begin
                    abortRun($sformatf("%s: the core did a %s where a %s was expected",
                        testName, we ? "write" : "read", ev.isWrite ? "write" : "read"));
                end else begin
                    compareAddr(testName, ev.addr, memAddr);
                    if (we) begin
                        compareData(testName, ev.data, writeData);
                        mem[memAddr] = writeData;   // Not read again before the rising edge
                    end
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        abortRun($sformatf("Timeout: tests still running after %0d clock cycles",
            watchdogCycles));
    end

    initial begin
        logic expectHalt;
        seed = 32'hc669dd3b;
        rst = 1'b1;
        for (int run = 0; run < numRuns; run++) begin
            rst = 1'b1;
            loadProgram();
            if (run % 4 == 3) plantIllegal();
            resetModel();
            expectHalt = 1'b0;
            for (int n = 0; n < instrPerRun && !expectHalt; n++) begin
                expectHalt = stepModel();
            end
            repeat (resetCycles) @(negedge clk);
            if (re || we) abortRun($sformatf("Run %0d: bus strobe active during reset", run));
            compareHalted($sformatf("run %0d in reset", run), 1'b0, halted);
            rst = 1'b0;
            eventNum = 0;
            while (expQ.size() != 0) begin
                @(negedge clk);
                sampleBus(run);
            end
            @(negedge clk);   // State after the last expected access
            compareHalted($sformatf("run %0d end", run), expectHalt, halted);
            if (expectHalt) begin
                repeat (5) begin   // Halt must stay quiet
                    @(negedge clk);
                    sampleBus(run);
                end
                compareHalted($sformatf("run %0d hold", run), 1'b1, halted);
            end
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
